// File: rtl/pipe_pkg.sv
package pipe_pkg;

    localparam int xlen = 32;

    // ####################
    // encodings
    // ####################

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct7 bit 5 turns f3_add into sub for op_op
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_cycle    = 12'hc00;
    localparam logic [11:0] csr_instret  = 12'hc02;

    // ####################
    // stage payloads
    // ####################

    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic            funct7_5;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic [6:0]      opcode;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc_plus_4;
        logic [11:0]     csr_addr;
        logic [xlen-1:0] csr_read_data;
        logic [xlen-1:0] csr_write_data;
        logic [xlen-1:0] pc;
    } ex_mem_t;

    typedef struct packed {
        ex_mem_t         ex;
        logic [xlen-1:0] load_data;
    } mem_wb_t;

    // value an instruction writes to rd, picked by its opcode
    function automatic logic [xlen-1:0] rd_value(
        input logic [6:0]      opcode,
        input logic [xlen-1:0] load_data,
        input logic [xlen-1:0] csr_data,
        input logic [xlen-1:0] imm,
        input logic [xlen-1:0] pc_plus_4,
        input logic [xlen-1:0] alu_result
    );
        case (opcode)
            op_load:         rd_value = load_data;
            op_system:       rd_value = csr_data;
            op_lui:          rd_value = imm;
            op_jal, op_jalr: rd_value = pc_plus_4;
            default:         rd_value = alu_result;
        endcase
    endfunction

endpackage

// File: rtl/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a valid entry
    always_ff @(posedge clk) begin
        if (load && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// File: rtl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue_valid,
    input  logic [4:0]  issue_rs1,
    input  logic [4:0]  issue_rs2,
    input  logic        ex_valid,
    input  logic [6:0]  ex_opcode,
    input  logic [4:0]  ex_rd,
    input  logic [4:0]  ex_rs1,
    input  logic [4:0]  ex_rs2,
    input  logic [11:0] ex_csr_addr,
    input  logic        mem_valid,
    input  logic [6:0]  mem_opcode,
    input  logic [4:0]  mem_rd,
    input  logic [11:0] mem_csr_addr,
    input  logic        wb_valid,
    input  logic [6:0]  wb_opcode,
    input  logic [4:0]  wb_rd,
    input  logic [11:0] wb_csr_addr,
    output logic        issue_ready,
    output logic        ex_bubble,
    output logic [1:0]  hazard_mem,
    output logic [1:0]  hazard_wb,
    output logic        csr_hazard_mem,
    output logic        csr_hazard_wb
);
    import pipe_pkg::*;

    typedef enum logic {
        st_run,
        st_stall
    } state_t;

    state_t state;
    logic   load_use;
    logic   mem_writes;
    logic   wb_writes;
    logic   ex_csr;

    function automatic logic writes_rd(input logic [6:0] opc);
        case (opc)
            op_load, op_op, op_op_imm, op_lui,
            op_jal, op_jalr, op_system: writes_rd = 1'b1;
            default:                    writes_rd = 1'b0;
        endcase
    endfunction

    // ####################
    // load-use stall
    // ####################

    assign load_use = issue_valid && ex_valid && (ex_opcode == op_load) &&
                      (ex_rd != 5'd0) && ((ex_rd == issue_rs1) || (ex_rd == issue_rs2));

    // stall marks the cycle in which ex holds the inserted bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_run;
        end else if ((state == st_run) && load_use) begin
            state <= st_stall;
        end else begin
            state <= st_run;
        end
    end

    assign issue_ready = !((state == st_run) && load_use);
    assign ex_bubble   = (state == st_run) && load_use;

    // ####################
    // forwarding hazards
    // ####################

    assign mem_writes = mem_valid && writes_rd(mem_opcode) && (mem_rd != 5'd0);
    assign wb_writes  = wb_valid && writes_rd(wb_opcode) && (wb_rd != 5'd0);

    assign hazard_mem = {mem_writes && (mem_rd == ex_rs2), mem_writes && (mem_rd == ex_rs1)};
    assign hazard_wb  = {wb_writes && (wb_rd == ex_rs2), wb_writes && (wb_rd == ex_rs1)};

    // only mscratch keeps written data, counter writes are dropped
    assign ex_csr = ex_valid && (ex_opcode == op_system);

    assign csr_hazard_mem = ex_csr && mem_valid && (mem_opcode == op_system) &&
                            (mem_csr_addr == ex_csr_addr) && (mem_csr_addr == csr_mscratch);
    assign csr_hazard_wb  = ex_csr && wb_valid && (wb_opcode == op_system) &&
                            (wb_csr_addr == ex_csr_addr) && (wb_csr_addr == csr_mscratch);

endmodule

// File: rtl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic [1:0]      hazard_mem,
    input  logic [1:0]      hazard_wb,
    input  logic [6:0]      mem_opcode,
    input  logic [xlen-1:0] mem_imm,
    input  logic [xlen-1:0] mem_alu_result,
    input  logic [xlen-1:0] mem_csr_read_data,
    input  logic [xlen-1:0] mem_load_data,
    input  logic [xlen-1:0] mem_pc_plus_4,
    input  logic [6:0]      wb_opcode,
    input  logic [xlen-1:0] wb_imm,
    input  logic [xlen-1:0] wb_alu_result,
    input  logic [xlen-1:0] wb_csr_read_data,
    input  logic [xlen-1:0] wb_load_data,
    input  logic [xlen-1:0] wb_pc_plus_4,
    input  logic            csr_hazard_mem,
    input  logic            csr_hazard_wb,
    input  logic [xlen-1:0] mem_csr_write_data,
    input  logic [xlen-1:0] wb_csr_write_data,
    input  logic [xlen-1:0] csr_read_data,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic [xlen-1:0] alu_src_a,
    output logic [xlen-1:0] alu_src_b,
    output logic [xlen-1:0] csr_forward_data
);
    import pipe_pkg::*;

    logic [xlen-1:0] mem_fwd;
    logic [xlen-1:0] wb_fwd;

    // what each downstream stage will put into rd
    assign mem_fwd = rd_value(mem_opcode, mem_load_data, mem_csr_read_data,
                              mem_imm, mem_pc_plus_4, mem_alu_result);
    assign wb_fwd  = rd_value(wb_opcode, wb_load_data, wb_csr_read_data,
                              wb_imm, wb_pc_plus_4, wb_alu_result);

    // newest producer wins
    always_comb begin
        if (hazard_mem[0]) begin
            alu_src_a = mem_fwd;
        end else if (hazard_wb[0]) begin
            alu_src_a = wb_fwd;
        end else begin
            alu_src_a = rs1_data;
        end

        if (hazard_mem[1]) begin
            alu_src_b = mem_fwd;
        end else if (hazard_wb[1]) begin
            alu_src_b = wb_fwd;
        end else begin
            alu_src_b = rs2_data;
        end

        if (csr_hazard_mem) begin
            csr_forward_data = mem_csr_write_data;
        end else if (csr_hazard_wb) begin
            csr_forward_data = wb_csr_write_data;
        end else begin
            csr_forward_data = csr_read_data;
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wd
);

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    assign wr_en = we && (rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wd;
        end
    end

    // a write in the same cycle passes straight to the read port
    assign rs1_data = (rs1 == 5'd0) ? '0 : (wr_en && (rd == rs1)) ? wd : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (wr_en && (rd == rs2)) ? wd : regs[rs2];

endmodule

// File: rtl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic            funct7_5,
    input  logic [xlen-1:0] src_a,
    input  logic [xlen-1:0] src_b,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] result
);
    import pipe_pkg::*;

    logic [xlen-1:0] operand_b;
    logic            is_sub;

    assign operand_b = (opcode == op_op) ? src_b : imm;
    assign is_sub    = (opcode == op_op) && funct7_5;

    always_comb begin
        result = '0;
        case (opcode)
            op_op, op_op_imm: begin
                case (funct3)
                    f3_add:  result = is_sub ? src_a - operand_b : src_a + operand_b;
                    f3_xor:  result = src_a ^ operand_b;
                    f3_or:   result = src_a | operand_b;
                    f3_and:  result = src_a & operand_b;
                    default: result = '0;
                endcase
            end
            // jump target and load address
            op_jalr, op_load: result = src_a + imm;
            default:          result = '0;
        endcase
    end

endmodule

// File: rtl/cycle_counter.sv
`timescale 1ns/1ps

module cycle_counter #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            retire,
    output logic [xlen-1:0] cycle,
    output logic [xlen-1:0] instret
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle   <= '0;
            instret <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (retire) begin
                instret <= instret + 1'b1;
            end
        end
    end

endmodule

// File: rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     rd_addr,
    output logic [xlen-1:0] rd_data,
    input  logic            we,
    input  logic [11:0]     wr_addr,
    input  logic [xlen-1:0] wr_data,
    input  logic            retire
);
    import pipe_pkg::*;

    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] cycle;
    logic [xlen-1:0] instret;

    cycle_counter #(
        .xlen(xlen)
    ) u_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .retire (retire),
        .cycle  (cycle),
        .instret(instret)
    );

    // counters are read-only here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (we && (wr_addr == csr_mscratch)) begin
            mscratch <= wr_data;
        end
    end

    always_comb begin
        case (rd_addr)
            csr_mscratch: rd_data = mscratch;
            csr_cycle:    rd_data = cycle;
            csr_instret:  rd_data = instret;
            default:      rd_data = '0;
        endcase
    end

endmodule

// File: rtl/exec_pipe_top.sv
`timescale 1ns/1ps

module exec_pipe_top #(
    parameter int xlen = pipe_pkg::xlen
) (
    input  logic            clk,
    input  logic            rst_n,
    // issue
    input  logic            issue_valid,
    output logic            issue_ready,
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic            funct7_5,
    input  logic [4:0]      rd,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pc,
    // memory
    output logic [xlen-1:0] mem_addr,
    output logic            mem_read,
    input  logic [xlen-1:0] mem_rdata,
    // retire
    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc,
    output logic [4:0]      retire_rd,
    output logic [xlen-1:0] retire_data
);
    import pipe_pkg::*;

    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    mem_wb_t         mem_wb_d;
    mem_wb_t         mem_wb_q;
    logic            ex_valid;
    logic            mem_valid;
    logic            wb_valid;
    logic            ex_bubble;
    logic [xlen-1:0] rf_rs1_data;
    logic [xlen-1:0] rf_rs2_data;
    logic [1:0]      hazard_mem;
    logic [1:0]      hazard_wb;
    logic            csr_hazard_mem;
    logic            csr_hazard_wb;
    logic [11:0]     ex_csr_addr;
    logic [xlen-1:0] csr_rd_data;
    logic [xlen-1:0] csr_rd_value;
    logic [xlen-1:0] csr_fwd_data;
    logic [xlen-1:0] alu_src_a;
    logic [xlen-1:0] alu_src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;

    // ####################
    // issue and id/ex
    // ####################

    reg_file #(
        .xlen(xlen)
    ) u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rf_rs1_data),
        .rs2_data(rf_rs2_data),
        .we      (wb_valid),
        .rd      (mem_wb_q.ex.rd),
        .wd      (wb_data)
    );

    assign id_ex_d = '{opcode: opcode, funct3: funct3, funct7_5: funct7_5, rd: rd,
                       rs1: rs1, rs2: rs2, rs1_data: rf_rs1_data, rs2_data: rf_rs2_data,
                       imm: imm, pc: pc};

    pipe_stage_reg #(
        .payload_t(id_ex_t)
    ) u_id_ex (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (1'b1),
        .bubble   (ex_bubble),
        .in_valid (issue_valid && issue_ready),
        .in_data  (id_ex_d),
        .out_valid(ex_valid),
        .out_data (id_ex_q)
    );

    // csr address sits in the i-type immediate
    assign ex_csr_addr = id_ex_q.imm[11:0];

    hazard_ctrl u_hazard (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_rs1     (rs1),
        .issue_rs2     (rs2),
        .ex_valid      (ex_valid),
        .ex_opcode     (id_ex_q.opcode),
        .ex_rd         (id_ex_q.rd),
        .ex_rs1        (id_ex_q.rs1),
        .ex_rs2        (id_ex_q.rs2),
        .ex_csr_addr   (ex_csr_addr),
        .mem_valid     (mem_valid),
        .mem_opcode    (ex_mem_q.opcode),
        .mem_rd        (ex_mem_q.rd),
        .mem_csr_addr  (ex_mem_q.csr_addr),
        .wb_valid      (wb_valid),
        .wb_opcode     (mem_wb_q.ex.opcode),
        .wb_rd         (mem_wb_q.ex.rd),
        .wb_csr_addr   (mem_wb_q.ex.csr_addr),
        .issue_ready   (issue_ready),
        .ex_bubble     (ex_bubble),
        .hazard_mem    (hazard_mem),
        .hazard_wb     (hazard_wb),
        .csr_hazard_mem(csr_hazard_mem),
        .csr_hazard_wb (csr_hazard_wb)
    );

    // ####################
    // execute
    // ####################

    csr_unit #(
        .xlen(xlen)
    ) u_csr (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_addr(ex_csr_addr),
        .rd_data(csr_rd_data),
        .we     (wb_valid && (mem_wb_q.ex.opcode == op_system)),
        .wr_addr(mem_wb_q.ex.csr_addr),
        .wr_data(mem_wb_q.ex.csr_write_data),
        .retire (wb_valid)
    );

    // instret seen from ex also counts the older instructions still in mem and wb
    assign csr_rd_value = (ex_csr_addr == csr_instret) ?
                          csr_rd_data + xlen'(mem_valid) + xlen'(wb_valid) : csr_rd_data;

    forward_unit #(
        .xlen(xlen)
    ) u_forward (
        .hazard_mem        (hazard_mem),
        .hazard_wb         (hazard_wb),
        .mem_opcode        (ex_mem_q.opcode),
        .mem_imm           (ex_mem_q.imm),
        .mem_alu_result    (ex_mem_q.alu_result),
        .mem_csr_read_data (ex_mem_q.csr_read_data),
        .mem_load_data     (mem_rdata),
        .mem_pc_plus_4     (ex_mem_q.pc_plus_4),
        .wb_opcode         (mem_wb_q.ex.opcode),
        .wb_imm            (mem_wb_q.ex.imm),
        .wb_alu_result     (mem_wb_q.ex.alu_result),
        .wb_csr_read_data  (mem_wb_q.ex.csr_read_data),
        .wb_load_data      (mem_wb_q.load_data),
        .wb_pc_plus_4      (mem_wb_q.ex.pc_plus_4),
        .csr_hazard_mem    (csr_hazard_mem),
        .csr_hazard_wb     (csr_hazard_wb),
        .mem_csr_write_data(ex_mem_q.csr_write_data),
        .wb_csr_write_data (mem_wb_q.ex.csr_write_data),
        .csr_read_data     (csr_rd_value),
        .rs1_data          (id_ex_q.rs1_data),
        .rs2_data          (id_ex_q.rs2_data),
        .alu_src_a         (alu_src_a),
        .alu_src_b         (alu_src_b),
        .csr_forward_data  (csr_fwd_data)
    );

    exec_alu #(
        .xlen(xlen)
    ) u_alu (
        .opcode  (id_ex_q.opcode),
        .funct3  (id_ex_q.funct3),
        .funct7_5(id_ex_q.funct7_5),
        .src_a   (alu_src_a),
        .src_b   (alu_src_b),
        .imm     (id_ex_q.imm),
        .result  (alu_result)
    );

    // csrrw writes rs1
    assign ex_mem_d = '{opcode: id_ex_q.opcode, rd: id_ex_q.rd, alu_result: alu_result,
                        imm: id_ex_q.imm, pc_plus_4: id_ex_q.pc + 32'd4,
                        csr_addr: ex_csr_addr, csr_read_data: csr_fwd_data,
                        csr_write_data: alu_src_a, pc: id_ex_q.pc};

    pipe_stage_reg #(
        .payload_t(ex_mem_t)
    ) u_ex_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (1'b1),
        .bubble   (1'b0),
        .in_valid (ex_valid),
        .in_data  (ex_mem_d),
        .out_valid(mem_valid),
        .out_data (ex_mem_q)
    );

    // ####################
    // memory and write-back
    // ####################

    assign mem_addr = ex_mem_q.alu_result;
    assign mem_read = mem_valid && (ex_mem_q.opcode == op_load);

    assign mem_wb_d = '{ex: ex_mem_q, load_data: mem_rdata};

    pipe_stage_reg #(
        .payload_t(mem_wb_t)
    ) u_mem_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (1'b1),
        .bubble   (1'b0),
        .in_valid (mem_valid),
        .in_data  (mem_wb_d),
        .out_valid(wb_valid),
        .out_data (mem_wb_q)
    );

    assign wb_data = rd_value(mem_wb_q.ex.opcode, mem_wb_q.load_data,
                              mem_wb_q.ex.csr_read_data, mem_wb_q.ex.imm,
                              mem_wb_q.ex.pc_plus_4, mem_wb_q.ex.alu_result);

    assign retire_valid = wb_valid;
    assign retire_pc    = mem_wb_q.ex.pc;
    assign retire_rd    = mem_wb_q.ex.rd;
    assign retire_data  = wb_data;

endmodule

// File: verif/exec_pipe_tb.sv
`timescale 1ns/1ps

module exec_pipe_tb;
    import pipe_pkg::*;

    localparam int n_instr     = 400;
    localparam int cycle_limit = 2 * n_instr + 50;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            issue_valid;
    logic            issue_ready;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_5;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] mem_addr;
    logic            mem_read;
    logic [xlen-1:0] mem_rdata;
    logic            retire_valid;
    logic [xlen-1:0] retire_pc;
    logic [4:0]      retire_rd;
    logic [xlen-1:0] retire_data;

    logic [31:0]     lfsr;
    logic [xlen-1:0] mem_words [64];
    logic [xlen-1:0] arch_regs [32];
    logic [xlen-1:0] arch_mscratch;
    logic [xlen-1:0] exp_pc [$];
    logic [4:0]      exp_rd [$];
    logic [xlen-1:0] exp_data [$];
    int              exp_edge [$];
    int              errors;
    int              tests_passed;
    int              tests_failed;
    int              edge_cnt;
    int              issued;
    int              generated;
    int              retired;
    int              stalls;

    exec_pipe_top #(
        .xlen(xlen)
    ) dut (.*);

    always #4 clk = ~clk;

    // memory answers in the same cycle
    assign mem_rdata = mem_words[mem_addr[7:2]];

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start, input string detail);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: pass %s", name, detail);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors %s", name, errors - err_start, detail);
        end
    endtask

    // ####################
    // program generator
    // ####################

    task automatic gen_instr();
        logic [3:0]      kind;
        logic [11:0]     imm12;
        logic [xlen-1:0] addr;
        kind     = 4'(rand_bits(4));
        imm12    = 12'(rand_bits(12));
        rd       = 5'(rand_bits(3));
        rs1      = 5'(rand_bits(3));
        rs2      = 5'(rand_bits(3));
        imm      = {{(xlen - 12){imm12[11]}}, imm12};
        pc       = 32'h1000 + 32'(generated * 4);
        funct7_5 = 1'b0;
        case (2'(rand_bits(2)))
            2'd0:    funct3 = f3_add;
            2'd1:    funct3 = f3_xor;
            2'd2:    funct3 = f3_or;
            default: funct3 = f3_and;
        endcase
        if (kind < 4'd4) begin
            opcode   = op_op;
            funct7_5 = (funct3 == f3_add) && (rand_bits(1) != 0);
        end else begin
            rs2 = 5'd0;
            if (kind < 4'd7) begin
                opcode = op_op_imm;
            end else if (kind < 4'd10) begin
                // aim at a word inside the 64-word memory
                opcode = op_load;
                funct3 = 3'b010;
                addr   = rand_bits(6) << 2;
                imm    = addr - arch_regs[rs1];
            end else if (kind < 4'd13) begin
                opcode = (kind == 4'd10) ? op_lui : (kind == 4'd11) ? op_jal : op_jalr;
                funct3 = 3'b000;
                if (kind != 4'd12) begin
                    rs1 = 5'd0;
                end
                if (kind == 4'd10) begin
                    imm = rand_bits(20) << 12;
                end
            end else begin
                opcode = op_system;
                funct3 = 3'b001;
                case (2'(rand_bits(2)))
                    2'd2:    imm = {20'h0, csr_cycle};
                    2'd3:    imm = {20'h0, csr_instret};
                    default: imm = {20'h0, csr_mscratch};
                endcase
            end
        end
        generated++;
    endtask

    // ####################
    // reference model
    // ####################

    task automatic model_exec();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] res;
        a    = arch_regs[rs1];
        b    = (opcode == op_op) ? arch_regs[rs2] : imm;
        addr = a + imm;
        case (opcode)
            op_op, op_op_imm: begin
                case (funct3)
                    f3_xor:  res = a ^ b;
                    f3_or:   res = a | b;
                    f3_and:  res = a & b;
                    default: res = ((opcode == op_op) && funct7_5) ? a - b : a + b;
                endcase
            end
            op_load:         res = mem_words[addr[7:2]];
            op_lui:          res = imm;
            op_jal, op_jalr: res = pc + 32'd4;
            op_system: begin
                case (imm[11:0])
                    csr_cycle:   res = xlen'(edge_cnt);
                    csr_instret: res = xlen'(issued);
                    default: begin
                        res           = arch_mscratch;
                        arch_mscratch = a;
                    end
                endcase
            end
            default:         res = '0;
        endcase
        if (rd != 5'd0) begin
            arch_regs[rd] = res;
        end
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        exp_edge.push_back(edge_cnt);
        issued++;
    endtask

    task automatic check_retire();
        int acc_edge;
        if (retire_valid) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("retire at pc %h with no instruction in flight", retire_pc);
            end else begin
                acc_edge = exp_edge.pop_front();
                check_pc("retire_pc", retire_pc, exp_pc.pop_front());
                check_reg("retire_rd", retire_rd, exp_rd.pop_front());
                check_word("retire_data", retire_data, exp_data.pop_front());
                if (edge_cnt != acc_edge + 2) begin
                    errors++;
                    $display("pc %h showed on the retire port %0d edges after acceptance, not 2",
                             retire_pc, edge_cnt - acc_edge);
                end
                retired++;
            end
        end
    endtask

    initial begin
        int              cycles;
        int              err_start;
        logic            accept;
        logic            pending;
        logic            timed_out;
        logic            exp_ready;
        logic [4:0]      ex_load_rd;
        logic            ex_load;
        logic            mem_load;
        logic [xlen-1:0] ex_load_addr;
        logic [xlen-1:0] mem_load_addr;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        opcode      = '0;
        funct3      = '0;
        funct7_5    = 1'b0;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        pc          = '0;
        lfsr        = 32'h4a21_4eae;
        errors      = 0;
        tests_passed = 0;
        tests_failed = 0;
        edge_cnt    = 0;
        issued      = 0;
        generated   = 0;
        retired     = 0;
        stalls      = 0;
        for (int i = 0; i < 64; i++) begin
            mem_words[i] = rand_bits(32);
        end
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        arch_mscratch = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        err_start = errors;
        @(negedge clk);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("mem_read", mem_read, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);
        report_test("reset_state", err_start, "");

        // ####################
        // random program
        // ####################

        err_start     = errors;
        cycles        = 0;
        accept        = 1'b0;
        pending       = 1'b0;
        timed_out     = 1'b0;
        ex_load_rd    = 5'd0;
        ex_load       = 1'b0;
        mem_load      = 1'b0;
        ex_load_addr  = '0;
        mem_load_addr = '0;
        while ((retired < n_instr) && !timed_out) begin
            @(posedge clk);
            edge_cnt++;
            // the load in ex moves on to mem
            mem_load      = ex_load;
            mem_load_addr = ex_load_addr;
            ex_load       = accept && (opcode == op_load);
            ex_load_addr  = arch_regs[rs1] + imm;
            if (accept) begin
                model_exec();
                pending = 1'b0;
            end
            // a load just accepted now sits in ex
            ex_load_rd = (accept && (opcode == op_load)) ? rd : 5'd0;
            #1;
            if (!pending) begin
                if ((generated < n_instr) && (rand_bits(3) != 0)) begin
                    gen_instr();
                    issue_valid = 1'b1;
                    pending     = 1'b1;
                end else begin
                    issue_valid = 1'b0;
                end
            end
            @(negedge clk);
            exp_ready = !(issue_valid && (ex_load_rd != 5'd0) &&
                          ((ex_load_rd == rs1) || (ex_load_rd == rs2)));
            if (!exp_ready) begin
                stalls++;
            end
            check_flag("issue_ready", issue_ready, exp_ready);
            check_flag("mem_read", mem_read, mem_load);
            if (mem_load) begin
                check_word("mem_addr", mem_addr, mem_load_addr);
            end
            check_retire();
            accept    = issue_valid && issue_ready;
            cycles++;
            timed_out = (cycles >= cycle_limit);
        end
        if (timed_out) begin
            errors++;
            $display("timeout after %0d cycles, %0d instructions never retired",
                     cycles, n_instr - retired);
        end
        report_test("random_program", err_start,
                    $sformatf("(%0d retired, %0d load-use stalls)", retired, stalls));

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/pipe_pkg.sv
rtl/pipe_stage_reg.sv
rtl/hazard_ctrl.sv
rtl/forward_unit.sv
rtl/reg_file.sv
rtl/exec_alu.sv
rtl/cycle_counter.sv
rtl/csr_unit.sv
rtl/exec_pipe_top.sv
verif/exec_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_pipe_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
